// File: program_flow_unit.f
logic/isa_pkg.sv
logic/flow_pkg.sv
logic/sync_ram.sv
logic/program_counter.sv
logic/stack_pointer.sv
logic/fetch_sequencer.sv
logic/program_flow_unit.sv
dv/program_flow_unit_tb.sv

// File: Makefile
TOP := program_flow_unit_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f program_flow_unit.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// File: dv/program_flow_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module program_flow_unit_tb
    import isa_pkg::*, flow_pkg::*;
();

    localparam int    clk_period     = 8;
    localparam int    imem_depth     = 256;
    localparam int    stack_depth    = 8;
    localparam addr_t stack_top      = 16'h018F;
    localparam int    imem_aw        = $clog2(imem_depth);
    localparam int    slot_w         = $clog2(stack_depth);
    localparam int    reset_cycles   = 16;
    localparam int    test_budget    = 150;  // worst case per test, load included
    localparam int    timeout_cycles = 2 * (4 * reset_cycles + 6 * test_budget);

    localparam word_t w_nop   = 16'h0000;
    localparam word_t w_jmp   = 16'h1000;
    localparam word_t w_call  = 16'h2000;
    localparam word_t w_ret   = 16'h3000;
    localparam word_t w_halt  = 16'hF000;
    localparam word_t w_other = 16'h7A5C;  // unknown opcode, runs as NOP

    logic  clk = 1'b0;
    logic  reset;
    logic  start;
    addr_t start_addr;
    logic  prog_we;
    addr_t prog_addr;
    word_t prog_data;
    addr_t pc;
    addr_t sp;
    logic  halted;
    logic  fault;
    logic  retire;

    word_t       image [imem_depth];         // mirror of the loaded program
    addr_t       model_stack [stack_depth];  // return addresses in the model
    int          model_depth;
    int          retire_count;
    int          errors = 0;
    int unsigned seed_value;

    program_flow_unit #(
        .imem_depth  (imem_depth),
        .stack_depth (stack_depth),
        .stack_top   (stack_top)
    ) u_program_flow_unit (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .start_addr (start_addr),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .pc         (pc),
        .sp         (sp),
        .halted     (halted),
        .fault      (fault),
        .retire     (retire)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(negedge clk) begin
        if (retire === 1'b1) begin
            retire_count++;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b1;
        model_depth = 0;  // stack empties, program memory is kept
    endtask

    task automatic write_word(input addr_t addr, input word_t data);
        @(posedge clk);
        #1;
        prog_we   = 1'b1;
        prog_addr = addr;
        prog_data = data;
        image[addr[imem_aw-1:0]] = data;
        @(posedge clk);
        #1;
        prog_we = 1'b0;
    endtask

    task automatic pulse_start(input addr_t addr);
        @(posedge clk);
        #1;
        start      = 1'b1;
        start_addr = addr;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_halted();
        int cycles;
        cycles = 0;
        while (halted !== 1'b1 && cycles < test_budget) begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            errors++;
            $display("error at %0t ns: the DUT never halted after start", $time);
        end
    endtask

    // steps through the mirrored program by the flow rules
    task automatic model_run(input addr_t start_at, output addr_t exp_pc,
                             output int exp_retires, output logic exp_fault);
        addr_t             mpc;
        addr_t             nxt;
        logic [3:0]        op;
        logic [slot_w-1:0] idx;
        logic              done;
        int                steps;
        mpc         = start_at;
        exp_retires = 0;
        exp_fault   = 1'b0;
        done        = 1'b0;
        steps       = 0;
        while (!done && steps < 64) begin
            op  = image[mpc[imem_aw-1:0]][15:12];
            nxt = mpc + 16'd1;
            steps++;
            case (op)
                op_halt: done = 1'b1;
                op_jmp: begin
                    mpc = image[nxt[imem_aw-1:0]];
                    exp_retires++;
                end
                op_call: begin
                    if (model_depth == stack_depth) begin
                        exp_fault = 1'b1;  // overflow, pc stays
                        done      = 1'b1;
                    end else begin
                        idx              = slot_w'(model_depth);
                        model_stack[idx] = mpc + 16'd2;
                        model_depth++;
                        mpc = image[nxt[imem_aw-1:0]];
                        exp_retires++;
                    end
                end
                op_ret: begin
                    if (model_depth == 0) begin
                        exp_fault = 1'b1;  // underflow
                        done      = 1'b1;
                    end else begin
                        model_depth--;
                        idx = slot_w'(model_depth);
                        mpc = model_stack[idx];
                        exp_retires++;
                    end
                end
                default: begin
                    mpc = nxt;
                    exp_retires++;
                end
            endcase
        end
        exp_pc = mpc;
    endtask

    task automatic run_program(input addr_t start_at);
        addr_t exp_pc;
        addr_t exp_sp;
        int    exp_retires;
        logic  exp_fault;
        retire_count = 0;
        pulse_start(start_at);
        wait_halted();
        model_run(start_at, exp_pc, exp_retires, exp_fault);
        exp_sp = stack_top - addr_t'(model_depth);
        if (pc !== exp_pc) report_mismatch("pc", 32'(pc), 32'(exp_pc));
        if (sp !== exp_sp) report_mismatch("sp", 32'(sp), 32'(exp_sp));
        if (fault !== exp_fault) report_mismatch("fault", 32'(fault), 32'(exp_fault));
        if (retire_count != exp_retires) begin
            report_mismatch("retire count", 32'(retire_count), 32'(exp_retires));
        end
    endtask

    task automatic check_reset();
        @(negedge clk);
        if (pc !== 16'h0000) report_mismatch("pc", 32'(pc), 32'h0);
        if (sp !== stack_top) report_mismatch("sp", 32'(sp), 32'(stack_top));
        if (halted !== 1'b1) report_mismatch("halted", 32'(halted), 32'h1);
        if (fault !== 1'b0) report_mismatch("fault", 32'(fault), 32'h0);
    endtask

    task automatic run_straight_line();
        int    n;
        addr_t base;
        n    = 4 + int'($urandom % 9);
        base = addr_t'($urandom % 200);
        $display("straight line: %0d words from %h", n, base);
        for (int i = 0; i < n; i++) begin
            write_word(base + addr_t'(i), (i % 3 == 2) ? w_other : w_nop);
        end
        write_word(base + addr_t'(n), w_halt);
        run_program(base);
        if (pc !== base + addr_t'(n)) report_mismatch("pc", 32'(pc), 32'(base + addr_t'(n)));
        if (retire_count != n) report_mismatch("retire count", 32'(retire_count), 32'(n));
        if (sp !== stack_top) report_mismatch("sp", 32'(sp), 32'(stack_top));
    endtask

    task automatic jump_to_target();
        addr_t base;
        addr_t dest;
        base = addr_t'($urandom % 100);
        dest = addr_t'(128 + $urandom % 120);
        $display("jump: %h to %h", base, dest);
        write_word(base, w_jmp);
        write_word(base + 16'd1, dest);
        write_word(dest, w_halt);
        run_program(base);
        if (pc !== dest) report_mismatch("pc", 32'(pc), 32'(dest));
        if (fault !== 1'b0) report_mismatch("fault", 32'(fault), 32'h0);
    endtask

    task automatic nested_calls();
        addr_t base;
        addr_t r1;
        addr_t r2;
        addr_t r3;
        base = addr_t'($urandom % 32);
        r1   = 16'h0040 + addr_t'($urandom % 16);
        r2   = 16'h0070 + addr_t'($urandom % 16);
        r3   = 16'h00A0 + addr_t'($urandom % 16);
        $display("nested calls: %h, %h, %h, %h", base, r1, r2, r3);
        write_word(base, w_call);
        write_word(base + 16'd1, r1);
        write_word(r1, w_call);
        write_word(r1 + 16'd1, r2);
        write_word(r2, w_call);
        write_word(r2 + 16'd1, r3);
        write_word(r3, w_halt);  // innermost routine stops here
        run_program(base);
        if (pc !== r3) report_mismatch("pc", 32'(pc), 32'(r3));
        if (sp !== stack_top - 16'd3) report_mismatch("sp", 32'(sp), 32'(stack_top - 16'd3));
    endtask

    task automatic call_then_return();
        addr_t base;
        addr_t sub;
        base = 16'h00C0 + addr_t'($urandom % 16);
        sub  = 16'h00E0 + addr_t'($urandom % 16);
        $display("call and return: %h calls %h", base, sub);
        apply_reset();  // start does not clear the stack
        write_word(base, w_call);
        write_word(base + 16'd1, sub);
        write_word(base + 16'd2, w_halt);
        write_word(sub, w_ret);
        run_program(base);
        if (pc !== base + 16'd2) report_mismatch("pc", 32'(pc), 32'(base + 16'd2));
        if (sp !== stack_top) report_mismatch("sp", 32'(sp), 32'(stack_top));
    endtask

    task automatic stack_overflow();
        addr_t base;
        addr_t last;
        base = addr_t'($urandom % 16);
        last = base + addr_t'(20 * stack_depth);
        $display("overflow: %0d calls from %h", stack_depth + 1, base);
        for (int k = 0; k <= stack_depth; k++) begin
            write_word(base + addr_t'(20 * k), w_call);
            write_word(base + addr_t'(20 * k + 1), base + addr_t'(20 * (k + 1)));
        end
        run_program(base);
        if (fault !== 1'b1) report_mismatch("fault", 32'(fault), 32'h1);
        if (halted !== 1'b1) report_mismatch("halted", 32'(halted), 32'h1);
        if (pc !== last) report_mismatch("pc", 32'(pc), 32'(last));
        if (sp !== stack_top - addr_t'(stack_depth)) begin
            report_mismatch("sp", 32'(sp), 32'(stack_top - addr_t'(stack_depth)));
        end
    endtask

    task automatic stack_underflow();
        addr_t ret_at;
        addr_t halt_at;
        ret_at  = addr_t'($urandom % 64);
        halt_at = 16'h0080 + addr_t'($urandom % 64);
        $display("underflow: ret at %h, restart at %h", ret_at, halt_at);
        apply_reset();
        write_word(ret_at, w_ret);
        write_word(halt_at, w_halt);
        run_program(ret_at);
        if (fault !== 1'b1) report_mismatch("fault", 32'(fault), 32'h1);
        if (pc !== ret_at) report_mismatch("pc", 32'(pc), 32'(ret_at));
        run_program(halt_at);  // fresh start drops the fault
        if (fault !== 1'b0) report_mismatch("fault", 32'(fault), 32'h0);
    endtask

    initial begin
        seed_value = $urandom(6);
        reset      = 1'b0;
        start      = 1'b0;
        start_addr = '0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        model_depth  = 0;
        retire_count = 0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b1;
        check_reset();
        run_straight_line();
        jump_to_target();
        nested_calls();
        call_then_return();
        stack_overflow();
        stack_underflow();
        $display("all tests done, %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(timeout_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the tests did not finish", timeout_cycles);
        $display("run stopped, %0d errors", errors);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/program_flow_unit.sv
`timescale 1ns/1ps
`default_nettype none

module program_flow_unit
    import isa_pkg::*, flow_pkg::*;
#(
    parameter int    imem_depth  = 256,
    parameter int    stack_depth = 8,
    parameter addr_t stack_top   = 16'h018F
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  addr_t start_addr,
    input  logic  prog_we,
    input  addr_t prog_addr,
    input  word_t prog_data,
    output addr_t pc,
    output addr_t sp,
    output logic  halted,
    output logic  fault,
    output logic  retire
);

    localparam int imem_aw = $clog2(imem_depth);
    localparam int slot_w  = $clog2(stack_depth);

    word_t              imem_rdata;
    addr_t              seq_imem_addr;
    logic               seq_imem_en;
    logic [imem_aw-1:0] imem_addr;
    logic               imem_en;
    logic               imem_we;
    logic               stack_we;
    addr_t              stack_wdata;
    addr_t              stack_rdata;
    logic [slot_w-1:0]  slot;
    logic               full;
    logic               empty;
    pc_ctrl_t           pc_ctrl;
    sp_ctrl_t           sp_ctrl;

    // load port owns the imem while halted
    assign imem_addr = halted ? prog_addr[imem_aw-1:0] : seq_imem_addr[imem_aw-1:0];
    assign imem_en   = halted ? prog_we : seq_imem_en;
    assign imem_we   = halted & prog_we;

    fetch_sequencer u_fetch_sequencer (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .imem_rdata  (imem_rdata),
        .full        (full),
        .empty       (empty),
        .pc          (pc),
        .imem_addr   (seq_imem_addr),
        .imem_en     (seq_imem_en),
        .stack_we    (stack_we),
        .stack_wdata (stack_wdata),
        .pc_ctrl     (pc_ctrl),
        .sp_ctrl     (sp_ctrl),
        .halted      (halted),
        .fault       (fault),
        .retire      (retire)
    );

    program_counter u_program_counter (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (pc_ctrl),
        .start_addr   (start_addr),
        .instr_target (imem_rdata),
        .stack_target (stack_rdata),
        .pc           (pc)
    );

    stack_pointer #(
        .stack_depth (stack_depth),
        .stack_top   (stack_top)
    ) u_stack_pointer (
        .clk   (clk),
        .reset (reset),
        .ctrl  (sp_ctrl),
        .sp    (sp),
        .slot  (slot),
        .full  (full),
        .empty (empty)
    );

    sync_ram #(
        .payload_t (word_t),
        .depth     (imem_depth)
    ) u_imem (
        .clk   (clk),
        .en    (imem_en),
        .we    (imem_we),
        .addr  (imem_addr),
        .wdata (prog_data),
        .rdata (imem_rdata)
    );

    sync_ram #(
        .payload_t (addr_t),
        .depth     (stack_depth)
    ) u_stack_ram (
        .clk   (clk),
        .en    (stack_we | sp_ctrl.pop),  // push writes, pop reads
        .we    (stack_we),
        .addr  (slot),
        .wdata (stack_wdata),
        .rdata (stack_rdata)
    );

endmodule

`default_nettype wire

// File: logic/fetch_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer
    import isa_pkg::*, flow_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  word_t    imem_rdata,
    input  logic     full,
    input  logic     empty,
    input  addr_t    pc,
    output addr_t    imem_addr,
    output logic     imem_en,
    output logic     stack_we,
    output addr_t    stack_wdata,
    output pc_ctrl_t pc_ctrl,
    output sp_ctrl_t sp_ctrl,
    output logic     halted,
    output logic     fault,
    output logic     retire
);

    typedef enum logic [2:0] {
        idle,
        fetch,
        decode,
        target,
        pop,
        ret_load
    } state_t;

    state_t state;
    state_t state_next;
    instr_t instr;
    logic   target_issued;  // target word read is in flight
    logic   call_pending;   // CALL rather than JMP in target
    logic   fault_set;

    assign instr       = instr_t'(imem_rdata);
    assign stack_wdata = pc + 16'd2;  // skip opcode and target word
    assign halted      = (state == idle);

    // overflow on CALL, underflow on RET
    assign fault_set = (state == decode) &&
                       ((instr.opcode == op_call && full) ||
                        (instr.opcode == op_ret && empty));

    always_comb begin
        state_next = state;
        imem_addr  = pc;
        imem_en    = 1'b0;
        stack_we   = 1'b0;
        pc_ctrl    = '0;
        sp_ctrl    = '0;
        retire     = 1'b0;
        case (state)
            idle: begin
                if (start) begin
                    pc_ctrl.load_start = 1'b1;
                    state_next         = fetch;
                end
            end
            fetch: begin
                imem_en    = 1'b1;  // opcode read at pc
                state_next = decode;
            end
            decode: begin
                if (fault_set) begin
                    state_next = idle;
                end else begin
                    case (instr.opcode)
                        op_jmp, op_call: state_next = target;
                        op_ret:          state_next = pop;
                        op_halt:         state_next = idle;  // pc stays on HALT
                        default: begin
                            pc_ctrl.incr = 1'b1;  // NOP and anything unknown
                            retire       = 1'b1;
                            state_next   = fetch;
                        end
                    endcase
                end
            end
            target: begin
                if (!target_issued) begin
                    imem_addr = pc + 16'd1;
                    imem_en   = 1'b1;
                end else begin
                    pc_ctrl.load_instr = 1'b1;
                    stack_we           = call_pending;  // return address goes with the load
                    sp_ctrl.push       = call_pending;
                    retire             = 1'b1;
                    state_next         = fetch;
                end
            end
            pop: begin
                sp_ctrl.pop = 1'b1;  // stack read of the top entry
                state_next  = ret_load;
            end
            ret_load: begin
                pc_ctrl.load_stack = 1'b1;
                retire             = 1'b1;
                state_next         = fetch;
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state         <= idle;
            fault         <= 1'b0;
            target_issued <= 1'b0;
            call_pending  <= 1'b0;
        end else begin
            state         <= state_next;
            target_issued <= (state == target) && !target_issued;
            if (state == idle && start) begin
                fault <= 1'b0;
            end else if (fault_set) begin
                fault <= 1'b1;  // sticky until next start
            end
            if (state == decode) begin
                call_pending <= (instr.opcode == op_call);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/stack_pointer.sv
`timescale 1ns/1ps
`default_nettype none

module stack_pointer
    import flow_pkg::*;
#(
    parameter int    stack_depth = 8,
    parameter addr_t stack_top   = 16'h018F,
    localparam int   depth_w     = $clog2(stack_depth + 1),
    localparam int   slot_w      = $clog2(stack_depth)
) (
    input  logic              clk,
    input  logic              reset,
    input  sp_ctrl_t          ctrl,
    output addr_t             sp,
    output logic [slot_w-1:0] slot,
    output logic              full,
    output logic              empty
);

    logic [depth_w-1:0] depth;  // live entries

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            depth <= '0;
        end else if (ctrl.push && !full) begin
            depth <= depth + 1'b1;
        end else if (ctrl.pop && !empty) begin
            depth <= depth - 1'b1;
        end
    end

    // push writes the next free slot, pop reads the top entry
    assign slot  = ctrl.pop ? slot_w'(depth - 1'b1) : slot_w'(depth);
    assign sp    = stack_top - addr_t'(depth);  // stack grows down
    assign full  = (depth == depth_w'(stack_depth));
    assign empty = (depth == '0);

endmodule

`default_nettype wire

// File: logic/program_counter.sv
`timescale 1ns/1ps
`default_nettype none

module program_counter
    import isa_pkg::*, flow_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  pc_ctrl_t ctrl,
    input  addr_t    start_addr,
    input  word_t    instr_target,   // straight from imem read data
    input  addr_t    stack_target,   // straight from stack read data
    output addr_t    pc
);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= '0;
        end else begin
            if (ctrl.load_start) begin
                pc <= start_addr;
            end else if (ctrl.load_instr) begin
                pc <= instr_target;  // JMP and CALL
            end else if (ctrl.load_stack) begin
                pc <= stack_target;  // RET
            end else if (ctrl.incr) begin
                pc <= pc + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/sync_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
    parameter type payload_t = logic [15:0],
    parameter int  depth     = 256,
    localparam int addr_w    = $clog2(depth)
) (
    input  logic              clk,
    input  logic              en,
    input  logic              we,
    input  logic [addr_w-1:0] addr,
    input  payload_t          wdata,
    output payload_t          rdata
);

    payload_t mem [depth];

    // one port, read returns old contents on a write
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];  // holds when en is low
        end
    end

endmodule

`default_nettype wire

// File: logic/flow_pkg.sv
`default_nettype none

package flow_pkg;

    // code address
    typedef logic [15:0] addr_t;

    // PC load strobes, priority follows field order
    typedef struct packed {
        logic load_start;  // from start_addr
        logic load_instr;  // jump target word
        logic load_stack;  // return address
        logic incr;
    } pc_ctrl_t;

    // stack strobes
    typedef struct packed {
        logic push;
        logic pop;
    } sp_ctrl_t;

endpackage

`default_nettype wire

// File: logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // one instruction or data word
    typedef logic [15:0] word_t;

    // opcode sits in the top nibble of the instruction
    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_jmp  = 4'd1,   // target in next word
        op_call = 4'd2,   // target in next word, pushes pc + 2
        op_ret  = 4'd3,   // pops return address
        op_halt = 4'd15
    } opcode_t;

    // operand field is reserved for the datapath
    typedef struct packed {
        opcode_t     opcode;
        logic [11:0] operand;
    } instr_t;

endpackage

`default_nettype wire
